//--- source/lq_config.svh
`ifndef LQ_CONFIG_SVH
`define LQ_CONFIG_SVH

// ----------------------------------------------------------------------
// Load queue sizing
// ----------------------------------------------------------------------

// Entries and index width, LQ_DEPTH must equal 2**LQ_IDX_W
`define LQ_DEPTH 8
`define LQ_IDX_W 3

// Physical address and one data word
`define LQ_ADDR_W 16
`define LQ_DATA_W 32
`define LQ_BYTES 4

// ----------------------------------------------------------------------
// Backend identifiers
// ----------------------------------------------------------------------

`define ROB_IDX_W 5
`define PREG_W 6

`endif

//--- source/lq_pkg.sv
`default_nettype none

`include "lq_config.svh"

package lq_pkg;

    // Queue position, dir flips on each wrap of idx
    typedef struct packed {
        logic                 dir;
        logic [`LQ_IDX_W-1:0] idx;
    } lq_idx_t;

    // Per-entry bookkeeping written by the load pipeline
    typedef struct packed {
        logic [`ROB_IDX_W-1:0] rob_idx;
        logic [`PREG_W-1:0]    rd;
        logic                  dir;
    } lq_meta_t;

    // Controller state
    typedef enum logic [0:0] {
        LQ_RUN,
        LQ_RECOVER
    } lq_state_t;

endpackage

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none

`include "lq_config.svh"

package mem_pkg;

    typedef enum logic [1:0] {
        LD_B,
        LD_H,
        LD_W
    } ld_op_t;

    // Load pipeline result, fwd_data holds the store-forwarded bytes
    typedef struct packed {
        logic                  en;
        lq_pkg::lq_idx_t       lq_idx;
        logic [`ROB_IDX_W-1:0] rob_idx;
        logic [`PREG_W-1:0]    rd;
        ld_op_t                op;
        logic [`LQ_ADDR_W-1:0] addr;
        logic                  miss;
        logic [`LQ_DATA_W-1:0] fwd_data;
    } ld_result_t;

    typedef struct packed {
        logic                  en;
        lq_pkg::lq_idx_t       lq_idx;
        logic [`LQ_ADDR_W-1:0] addr;
        logic [`LQ_BYTES-1:0]  mask;
    } store_probe_t;

    typedef struct packed {
        logic                  en;
        lq_pkg::lq_idx_t       lq_idx;
        logic [`LQ_DATA_W-1:0] data;
    } refill_t;

    typedef struct packed {
        logic                  en;
        logic [`ROB_IDX_W-1:0] rob_idx;
        logic [`PREG_W-1:0]    rd;
        logic [`LQ_DATA_W-1:0] data;
    } wb_t;

    typedef struct packed {
        logic                  en;
        lq_pkg::lq_idx_t       lq_idx;
        logic [`ROB_IDX_W-1:0] rob_idx;
    } violation_t;

endpackage

`default_nettype wire

//--- source/lq_ctrl.sv
`default_nettype none

`include "lq_config.svh"

module lq_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 disp_en,
    input  logic [1:0]           commit_num,
    input  logic                 redirect,
    input  lq_pkg::lq_idx_t      redirect_idx,
    output lq_pkg::lq_idx_t      alloc_idx,
    output lq_pkg::lq_idx_t      head,
    output logic [`LQ_DEPTH-1:0] valid_window,
    output logic [`LQ_DEPTH-1:0] flush_mask,
    output logic [`LQ_IDX_W:0]   credit_ret
);
    import lq_pkg::*;

    lq_idx_t   head_q;
    lq_idx_t   tail_q;
    lq_idx_t   restore_q;
    lq_state_t state_q;

    logic [`LQ_IDX_W:0] live_cnt;
    logic [`LQ_IDX_W:0] flush_cnt;

    assign alloc_idx = tail_q;
    assign head      = head_q;

    // Wrap bit makes the pointer distance exact, a full queue gives LQ_DEPTH
    assign live_cnt  = tail_q - head_q;
    assign flush_cnt = tail_q - restore_q;

    // ----------------------------------------------------------------------
    // Age masks
    // ----------------------------------------------------------------------
    always_comb begin
        logic [`LQ_IDX_W-1:0] off_head;
        logic [`LQ_IDX_W-1:0] off_restore;
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            off_head        = i[`LQ_IDX_W-1:0] - head_q.idx;
            off_restore     = i[`LQ_IDX_W-1:0] - restore_q.idx;
            valid_window[i] = {1'b0, off_head} < live_cnt;
            // Everything from the restore point up to the old tail goes away
            flush_mask[i]   = (state_q == LQ_RECOVER) && ({1'b0, off_restore} < flush_cnt);
        end
    end

    always_comb begin
        credit_ret = {{(`LQ_IDX_W-1){1'b0}}, commit_num};
        if (state_q == LQ_RECOVER) begin
            credit_ret = credit_ret + flush_cnt;
        end
    end

    // ----------------------------------------------------------------------
    // Pointers and recovery state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q    <= '0;
            tail_q    <= '0;
            restore_q <= '0;
            state_q   <= LQ_RUN;
        end else begin
            head_q <= head_q + commit_num;
            case (state_q)
                LQ_RUN: begin
                    if (redirect) begin
                        state_q   <= LQ_RECOVER;
                        restore_q <= redirect_idx;
                    end
                    if (disp_en) begin
                        tail_q <= tail_q + 1'b1;
                    end
                end
                LQ_RECOVER: begin
                    state_q <= LQ_RUN;
                    tail_q  <= restore_q;
                end
                default: state_q <= LQ_RUN;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/lq_entry_store.sv
`default_nettype none

`include "lq_config.svh"

module lq_entry_store (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  disp_en,
    input  lq_pkg::lq_idx_t       alloc_idx,
    input  logic [1:0]            commit_num,
    input  lq_pkg::lq_idx_t       head,
    input  logic [`LQ_DEPTH-1:0]  flush_mask,
    input  mem_pkg::ld_result_t   ld_result,
    input  mem_pkg::refill_t      refill,
    input  lq_pkg::lq_idx_t       wb_done_idx,
    input  logic                  wb_done,
    output logic [`LQ_ADDR_W-1:0] entry_addr [`LQ_DEPTH],
    output logic [`LQ_BYTES-1:0]  entry_mask [`LQ_DEPTH],
    output logic [`LQ_DEPTH-1:0]  executed,
    output logic [`LQ_DEPTH-1:0]  ready,
    output lq_pkg::lq_meta_t      entry_meta [`LQ_DEPTH],
    output logic [`LQ_DATA_W-1:0] entry_data [`LQ_DEPTH]
);
    import lq_pkg::*;
    import mem_pkg::*;

    logic [`LQ_DEPTH-1:0] valid_q;
    logic [`LQ_DEPTH-1:0] executed_q;
    logic [`LQ_DEPTH-1:0] miss_q;
    logic [`LQ_DEPTH-1:0] data_valid_q;
    logic [`LQ_DEPTH-1:0] written_back_q;

    logic [`LQ_BYTES-1:0]  ld_mask;
    logic [`LQ_DATA_W-1:0] merged;
    lq_meta_t              ld_meta;

    assign executed = executed_q;
    assign ready    = valid_q & miss_q & data_valid_q & ~written_back_q;

    // Byte lanes touched by the load
    always_comb begin
        case (ld_result.op)
            LD_B:    ld_mask = {{(`LQ_BYTES-1){1'b0}}, 1'b1} << ld_result.addr[1:0];
            LD_H:    ld_mask = {{(`LQ_BYTES-2){1'b0}}, 2'b11} << {ld_result.addr[1], 1'b0};
            default: ld_mask = '1;
        endcase
        ld_meta.rob_idx = ld_result.rob_idx;
        ld_meta.rd      = ld_result.rd;
        ld_meta.dir     = ld_result.lq_idx.dir;
    end

    // Forwarded bytes stay, the rest comes from the refill line
    always_comb begin
        for (int b = 0; b < `LQ_BYTES; b++) begin
            merged[b*8 +: 8] = entry_mask[refill.lq_idx.idx][b]
                             ? entry_data[refill.lq_idx.idx][b*8 +: 8]
                             : refill.data[b*8 +: 8];
        end
    end

    // ----------------------------------------------------------------------
    // Status bits
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q        <= '0;
            executed_q     <= '0;
            miss_q         <= '0;
            data_valid_q   <= '0;
            written_back_q <= '0;
        end else begin
            if (disp_en) begin
                valid_q[alloc_idx.idx]        <= 1'b1;
                executed_q[alloc_idx.idx]     <= 1'b0;
                miss_q[alloc_idx.idx]         <= 1'b0;
                data_valid_q[alloc_idx.idx]   <= 1'b0;
                written_back_q[alloc_idx.idx] <= 1'b0;
            end
            if (ld_result.en) begin
                executed_q[ld_result.lq_idx.idx]     <= 1'b1;
                miss_q[ld_result.lq_idx.idx]         <= ld_result.miss;
                data_valid_q[ld_result.lq_idx.idx]   <= !ld_result.miss;
                // A hit went out through the pipeline already
                written_back_q[ld_result.lq_idx.idx] <= !ld_result.miss;
            end
            if (refill.en) begin
                data_valid_q[refill.lq_idx.idx] <= 1'b1;
            end
            if (wb_done) begin
                written_back_q[wb_done_idx.idx] <= 1'b1;
            end
            for (int k = 0; k < 2; k++) begin
                if (k < commit_num) begin
                    valid_q[head.idx + k[`LQ_IDX_W-1:0]]    <= 1'b0;
                    executed_q[head.idx + k[`LQ_IDX_W-1:0]] <= 1'b0;
                end
            end
            for (int i = 0; i < `LQ_DEPTH; i++) begin
                if (flush_mask[i]) begin
                    valid_q[i]    <= 1'b0;
                    executed_q[i] <= 1'b0;
                end
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (ld_result.en) begin
            entry_addr[ld_result.lq_idx.idx] <= ld_result.addr;
            entry_mask[ld_result.lq_idx.idx] <= ld_mask;
            entry_data[ld_result.lq_idx.idx] <= ld_result.fwd_data;
            entry_meta[ld_result.lq_idx.idx] <= ld_meta;
        end
        if (refill.en) begin
            entry_data[refill.lq_idx.idx] <= merged;
        end
    end

endmodule

`default_nettype wire

//--- source/lq_violation_check.sv
`default_nettype none

`include "lq_config.svh"

module lq_violation_check (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mem_pkg::store_probe_t probe,
    input  lq_pkg::lq_idx_t       head,
    input  logic [`LQ_DEPTH-1:0]  valid_window,
    input  logic [`LQ_DEPTH-1:0]  executed,
    input  logic [`LQ_ADDR_W-1:0] entry_addr [`LQ_DEPTH],
    input  logic [`LQ_BYTES-1:0]  entry_mask [`LQ_DEPTH],
    input  lq_pkg::lq_meta_t      entry_meta [`LQ_DEPTH],
    output mem_pkg::violation_t   violation
);
    import lq_pkg::*;

    logic [`LQ_IDX_W:0]   store_off;
    logic                 behind_head;
    logic [`LQ_DEPTH-1:0] hit_vec;
    logic [`LQ_DEPTH-1:0] hit_q;
    logic [`LQ_IDX_W-1:0] head_q;
    logic [`LQ_IDX_W-1:0] sel_idx;
    lq_meta_t             sel_meta;

    // Store position in age order, counted from the head
    assign store_off   = probe.lq_idx - head;
    // Older loads already committed, so every live load is younger
    assign behind_head = store_off > `LQ_DEPTH;

    // ----------------------------------------------------------------------
    // Stage 1: address match against younger executed loads
    // ----------------------------------------------------------------------
    always_comb begin
        logic [`LQ_IDX_W-1:0] ent_off;
        logic                 same_word;
        logic                 overlap;
        logic                 younger;
        for (int i = 0; i < `LQ_DEPTH; i++) begin
            ent_off    = i[`LQ_IDX_W-1:0] - head.idx;
            same_word  = entry_addr[i][`LQ_ADDR_W-1:2] == probe.addr[`LQ_ADDR_W-1:2];
            overlap    = |(entry_mask[i] & probe.mask);
            younger    = behind_head || ({1'b0, ent_off} >= store_off);
            hit_vec[i] = probe.en && valid_window[i] && executed[i] && younger
                         && same_word && overlap;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_q  <= '0;
            head_q <= '0;
        end else begin
            hit_q  <= hit_vec;
            head_q <= head.idx;
        end
    end

    // ----------------------------------------------------------------------
    // Stage 2: oldest hit, scanning up from the head
    // ----------------------------------------------------------------------
    always_comb begin
        logic [`LQ_IDX_W-1:0] j;
        sel_idx = head_q;
        for (int k = `LQ_DEPTH - 1; k >= 0; k--) begin
            j = head_q + k[`LQ_IDX_W-1:0];
            if (hit_q[j]) begin
                sel_idx = j;
            end
        end
        sel_meta = entry_meta[sel_idx];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            violation <= '0;
        end else begin
            violation.en         <= |hit_q;
            violation.lq_idx.dir <= sel_meta.dir;
            violation.lq_idx.idx <= sel_idx;
            violation.rob_idx    <= sel_meta.rob_idx;
        end
    end

endmodule

`default_nettype wire

//--- source/lq_writeback_sel.sv
`default_nettype none

`include "lq_config.svh"

module lq_writeback_sel (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`LQ_DEPTH-1:0]  ready,
    input  lq_pkg::lq_meta_t      entry_meta [`LQ_DEPTH],
    input  logic [`LQ_DATA_W-1:0] entry_data [`LQ_DEPTH],
    input  logic                  wb_credit,
    output mem_pkg::wb_t          wb_out,
    output logic                  wb_done,
    output lq_pkg::lq_idx_t       wb_done_idx
);
    logic [`LQ_IDX_W:0]    credit_q;
    logic [`LQ_IDX_W-1:0]  sel_idx;
    logic                  issue;
    logic                  wb_en_q;
    logic [`ROB_IDX_W-1:0] wb_rob_q;
    logic [`PREG_W-1:0]    wb_rd_q;
    logic [`LQ_DATA_W-1:0] wb_data_q;

    // Lowest ready index wins
    always_comb begin
        sel_idx = '0;
        for (int i = `LQ_DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel_idx = i[`LQ_IDX_W-1:0];
            end
        end
    end

    assign issue           = (|ready) && (credit_q != '0);
    assign wb_done         = issue;
    assign wb_done_idx.dir = entry_meta[sel_idx].dir;
    assign wb_done_idx.idx = sel_idx;

    // Credits granted by the result bus, saturating
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_q <= '0;
            wb_en_q  <= 1'b0;
        end else begin
            wb_en_q <= issue;
            if (wb_credit && !issue && !(&credit_q)) begin
                credit_q <= credit_q + 1'b1;
            end else if (!wb_credit && issue) begin
                credit_q <= credit_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            wb_rob_q  <= entry_meta[sel_idx].rob_idx;
            wb_rd_q   <= entry_meta[sel_idx].rd;
            wb_data_q <= entry_data[sel_idx];
        end
    end

    assign wb_out.en      = wb_en_q;
    assign wb_out.rob_idx = wb_rob_q;
    assign wb_out.rd      = wb_rd_q;
    assign wb_out.data    = wb_data_q;

endmodule

`default_nettype wire

//--- source/load_queue.sv
`default_nettype none

`include "lq_config.svh"

module load_queue (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  disp_en,
    output lq_pkg::lq_idx_t       alloc_idx,
    output logic [`LQ_IDX_W:0]    credit_ret,
    input  logic [1:0]            commit_num,
    input  logic                  redirect,
    input  lq_pkg::lq_idx_t       redirect_idx,
    input  mem_pkg::ld_result_t   ld_result,
    input  mem_pkg::refill_t      refill,
    input  mem_pkg::store_probe_t probe,
    input  logic                  wb_credit,
    output mem_pkg::wb_t          wb_out,
    output mem_pkg::violation_t   violation
);
    import lq_pkg::*;

    lq_idx_t               head;
    logic [`LQ_DEPTH-1:0]  valid_window;
    logic [`LQ_DEPTH-1:0]  flush_mask;
    logic [`LQ_DEPTH-1:0]  executed;
    logic [`LQ_DEPTH-1:0]  ready;
    logic [`LQ_ADDR_W-1:0] entry_addr [`LQ_DEPTH];
    logic [`LQ_BYTES-1:0]  entry_mask [`LQ_DEPTH];
    lq_meta_t              entry_meta [`LQ_DEPTH];
    logic [`LQ_DATA_W-1:0] entry_data [`LQ_DEPTH];
    lq_idx_t               wb_done_idx;
    logic                  wb_done;

    // ----------------------------------------------------------------------
    // Control and datapath
    // ----------------------------------------------------------------------
    lq_ctrl u_ctrl (.*);

    lq_entry_store u_entry_store (.*);

    lq_violation_check u_violation_check (.*);

    lq_writeback_sel u_writeback_sel (.*);

endmodule

`default_nettype wire

//--- verification/tb_load_queue.sv
`default_nettype none

`include "lq_config.svh"

module tb_load_queue;
    timeunit 1ns;
    timeprecision 100ps;

    import lq_pkg::*;
    import mem_pkg::*;

    localparam int TEST_CYCLES = 130;

    logic                  clk;
    logic                  rst_n;
    logic                  disp_en;
    logic [1:0]            commit_num;
    logic                  redirect;
    lq_idx_t               redirect_idx;
    ld_result_t            ld_result;
    refill_t               refill;
    store_probe_t          probe;
    logic                  wb_credit;
    lq_idx_t               alloc_idx;
    logic [`LQ_IDX_W:0]    credit_ret;
    wb_t                   wb_out;
    violation_t            violation;

    // Reference queue
    lq_idx_t               ref_head;
    lq_idx_t               ref_tail;
    logic [`LQ_DEPTH-1:0]  ref_dir;
    logic [`LQ_DEPTH-1:0]  ref_exec;
    logic [`LQ_ADDR_W-1:0] ref_addr [`LQ_DEPTH];
    logic [`LQ_BYTES-1:0]  ref_mask [`LQ_DEPTH];
    logic [`LQ_DATA_W-1:0] ref_fwd [`LQ_DEPTH];
    logic [`LQ_DATA_W-1:0] ref_data [`LQ_DEPTH];
    logic [`ROB_IDX_W-1:0] ref_rob [`LQ_DEPTH];
    logic [`PREG_W-1:0]    ref_rd [`LQ_DEPTH];

    violation_t viol_exp;
    wb_t        exp_wb [64];
    int         wr_ptr;
    int         rd_ptr;
    int         wb_granted;
    int         credits;
    int         ret_sum;
    int         freed_sum;
    logic       wb_seen;
    logic       sync_chk;

    load_queue i_dut (.*);

    always #4 clk = ~clk;

    // ----------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------
    task automatic report_fail(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "Check failed");
    endtask

    reset_idle: assert property (@(posedge clk)
        !rst_n |-> (!wb_out.en && !violation.en && credit_ret == '0))
        else report_fail("outputs active during reset");

    alloc_order: assert property (@(posedge clk) disable iff (!rst_n)
        alloc_idx == ref_tail)
        else report_fail("alloc_idx differs from the expected tail");

    credit_floor: assert property (@(posedge clk) disable iff (!rst_n)
        credits >= 0)
        else report_fail("dispatch credits below zero");

    credit_sum: assert property (@(posedge clk) disable iff (!rst_n)
        ret_sum == freed_sum)
        else report_fail("returned credits differ from freed entries");

    wb_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        wb_out.en |-> (rd_ptr < wr_ptr && wb_granted > rd_ptr))
        else report_fail("unexpected writeback");

    wb_payload: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_out.en && rd_ptr < wr_ptr) |-> (wb_out.rob_idx == exp_wb[rd_ptr].rob_idx
            && wb_out.rd == exp_wb[rd_ptr].rd && wb_out.data == exp_wb[rd_ptr].data))
        else report_fail("writeback payload mismatch");

    wb_complete: assert property (@(posedge clk) disable iff (!rst_n)
        sync_chk |-> rd_ptr == wr_ptr)
        else report_fail("expected writeback missing");

    viol_presence: assert property (@(posedge clk) disable iff (!rst_n)
        violation.en == $past(viol_exp.en, 2))
        else report_fail("violation report presence mismatch");

    viol_fields: assert property (@(posedge clk) disable iff (!rst_n)
        violation.en |-> (violation.lq_idx == $past(viol_exp.lq_idx, 2)
            && violation.rob_idx == $past(viol_exp.rob_idx, 2)))
        else report_fail("violation names the wrong load");

    // ----------------------------------------------------------------------
    // Stimulus helpers
    // ----------------------------------------------------------------------
    function automatic logic [3:0] lane_mask(input ld_op_t op, input logic [1:0] low);
        case (op)
            LD_B:    lane_mask = 4'b0001 << low;
            LD_H:    lane_mask = low[1] ? 4'b1100 : 4'b0011;
            default: lane_mask = 4'b1111;
        endcase
    endfunction

    task automatic clear_inputs();
        disp_en      = 1'b0;
        commit_num   = 2'd0;
        redirect     = 1'b0;
        redirect_idx = '0;
        ld_result    = '0;
        refill       = '0;
        probe        = '0;
        wb_credit    = 1'b0;
        viol_exp     = '0;
        sync_chk     = 1'b0;
    endtask

    // One clock cycle, entered and left on a falling edge
    task automatic step();
        #2;
        credits = credits + int'(credit_ret) - int'(disp_en);
        ret_sum = ret_sum + int'(credit_ret);
        @(posedge clk);
        @(negedge clk);
        if (wb_seen) begin
            rd_ptr++;
        end
        wb_seen = wb_out.en;
        clear_inputs();
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    task automatic sync_writebacks();
        idle(3);
        sync_chk = 1'b1;
        step();
    endtask

    task automatic dispatch(input int n);
        repeat (n) begin
            disp_en = 1'b1;
            step();
            ref_dir[ref_tail.idx]  = ref_tail.dir;
            ref_exec[ref_tail.idx] = 1'b0;
            ref_tail = ref_tail + 4'd1;
        end
    endtask

    task automatic execute(input int slot, input ld_op_t op, input logic [15:0] addr,
                           input logic miss);
        ld_result.en       = 1'b1;
        ld_result.lq_idx   = {ref_dir[slot], slot[2:0]};
        ld_result.rob_idx  = 5'($urandom);
        ld_result.rd       = 6'($urandom);
        ld_result.op       = op;
        ld_result.addr     = addr;
        ld_result.miss     = miss;
        ld_result.fwd_data = $urandom;
        ref_addr[slot] = addr;
        ref_mask[slot] = lane_mask(op, addr[1:0]);
        ref_fwd[slot]  = ld_result.fwd_data;
        ref_rob[slot]  = ld_result.rob_idx;
        ref_rd[slot]   = ld_result.rd;
        ref_exec[slot] = 1'b1;
        step();
    endtask

    // Forwarded bytes win over the refill line
    task automatic refill_line(input int slot);
        logic [31:0] line;
        line = $urandom;
        for (int b = 0; b < 4; b++) begin
            ref_data[slot][b*8 +: 8] = ref_mask[slot][b] ? ref_fwd[slot][b*8 +: 8]
                                                         : line[b*8 +: 8];
        end
        refill.en     = 1'b1;
        refill.lq_idx = {ref_dir[slot], slot[2:0]};
        refill.data   = line;
        step();
    endtask

    task automatic expect_wb(input int slot);
        exp_wb[wr_ptr].en      = 1'b1;
        exp_wb[wr_ptr].rob_idx = ref_rob[slot];
        exp_wb[wr_ptr].rd      = ref_rd[slot];
        exp_wb[wr_ptr].data    = ref_data[slot];
        wr_ptr++;
    endtask

    task automatic grant();
        wb_credit = 1'b1;
        wb_granted++;
        step();
    endtask

    task automatic commit(input int n);
        commit_num = n[1:0];
        freed_sum  = freed_sum + n;
        step();
        repeat (n) begin
            ref_exec[ref_head.idx] = 1'b0;
            ref_head = ref_head + 4'd1;
        end
    endtask

    task automatic flush_from(input lq_idx_t target);
        logic [3:0] n;
        n = ref_tail - target;
        redirect     = 1'b1;
        redirect_idx = target;
        step();
        // Recovery cycle returns the flushed entries
        freed_sum = freed_sum + int'(n);
        step();
        for (int k = 0; k < int'(n); k++) begin
            ref_exec[target.idx + k[2:0]] = 1'b0;
        end
        ref_tail = target;
    endtask

    // Oldest executed load at or after the store position that overlaps it
    task automatic store_probe(input lq_idx_t pos, input logic [15:0] addr,
                               input logic [3:0] mask);
        logic [3:0] live;
        logic [3:0] start;
        logic [2:0] j;
        live  = ref_tail - ref_head;
        start = pos - ref_head;
        // A store behind the head is older than every live load
        if (start > 4'd8) begin
            start = 4'd0;
        end
        for (int k = 7; k >= 0; k--) begin
            j = ref_head.idx + k[2:0];
            if (k >= int'(start) && k < int'(live) && ref_exec[j]
                && ref_addr[j][15:2] == addr[15:2] && (ref_mask[j] & mask) != 4'd0) begin
                viol_exp.en      = 1'b1;
                viol_exp.lq_idx  = {ref_dir[j], j};
                viol_exp.rob_idx = ref_rob[j];
            end
        end
        probe.en     = 1'b1;
        probe.lq_idx = pos;
        probe.addr   = addr;
        probe.mask   = mask;
        step();
        idle(2);
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        void'($urandom(32'h1f48));
        clk        = 1'b0;
        rst_n      = 1'b0;
        ref_head   = '0;
        ref_tail   = '0;
        ref_dir    = '0;
        ref_exec   = '0;
        wr_ptr     = 0;
        rd_ptr     = 0;
        wb_granted = 0;
        credits    = `LQ_DEPTH;
        ret_sum    = 0;
        freed_sum  = 0;
        wb_seen    = 1'b0;
        clear_inputs();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Fill the queue with hits, three of them share word 0x0100
        dispatch(8);
        for (int i = 0; i < 8; i++) begin
            if (i == 2 || i == 6) begin
                execute(i, LD_B, 16'h0100, 1'b0);
            end else if (i == 5) begin
                execute(i, LD_H, 16'h0102, 1'b0);
            end else begin
                execute(i, ld_op_t'($urandom % 3),
                        16'h2000 + 16'(i * 16) + 16'($urandom % 4), 1'b0);
            end
        end
        store_probe({1'b0, 3'd3}, 16'h0100, 4'b1111);
        store_probe({1'b0, 3'd7}, 16'h0100, 4'b1111);
        store_probe({1'b0, 3'd0}, 16'h0100, 4'b0010);
        store_probe({1'b0, 3'd0}, 16'h0100, 4'b0001);
        store_probe({1'b0, 3'd0}, 16'h0103, 4'b1000);
        repeat (4) commit(2);

        // Misses refilled out of order while the result bus holds back
        dispatch(4);
        for (int i = 0; i < 4; i++) begin
            execute(i, ld_op_t'($urandom % 3), 16'h3000 + 16'(i * 4) + 16'($urandom % 4),
                    1'b1);
        end
        for (int i = 3; i >= 0; i--) begin
            refill_line(i);
        end
        sync_writebacks();
        for (int i = 0; i < 4; i++) begin
            expect_wb(i);
            grant();
            sync_writebacks();
        end
        commit(2);
        commit(2);

        // Single miss with a credit already held
        dispatch(1);
        execute(4, LD_H, 16'h4002, 1'b1);
        grant();
        refill_line(4);
        expect_wb(4);
        sync_writebacks();
        commit(1);

        // Redirect drops two pending misses and one unexecuted entry
        dispatch(4);
        execute(5, LD_W, 16'h5000, 1'b0);
        execute(6, LD_W, 16'h5004, 1'b1);
        execute(7, LD_B, 16'h5009, 1'b1);
        grant();
        flush_from({1'b1, 3'd6});
        refill_line(6);
        refill_line(7);
        sync_writebacks();
        dispatch(2);
        commit(1);
        commit(2);
        sync_writebacks();

        $display("Simulation passed");
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 8 + 400);
        $display("Timeout: the test did not finish within %0d ns", TEST_CYCLES * 8 + 400);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/lq_pkg.sv
source/mem_pkg.sv
source/lq_ctrl.sv
source/lq_entry_store.sv
source/lq_violation_check.sv
source/lq_writeback_sel.sv
source/load_queue.sv
verification/tb_load_queue.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_load_queue -o tb_load_queue \
    && ./obj_dir/tb_load_queue \
    || { echo "Run ended with an error"; exit 1; }
